/* verilog.f */
src/rotatorPkg.sv
src/rotatorIf.sv
src/coeffDecode.sv
src/complexMultiply.sv
src/rotateResult.sv
src/phaseRotator.sv
sim/phaseRotator_asserts.sv
sim/phaseRotatorTb.sv

/* Makefile */
TOP = phaseRotatorTb

.PHONY: sim clean

# The run passes only if the pass message shows up in the model output
sim:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

/* sim/phaseRotatorTb.sv */
/*
 * Testbench for the phase rotator: clock, LCG stimulus, reference model,
 * scoreboard and the closing report
 */
module phaseRotatorTb import rotatorPkg::*;;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int rotBits = 8;
   localparam int drainLimit = 10;
   localparam logic signed [rotBits-1:0] maxSample = {1'b0, {(rotBits-1){1'b1}}};
   localparam logic signed [rotBits-1:0] minSample = {1'b1, {(rotBits-1){1'b0}}};

   // One scoreboard entry, the expected outputs of one captured sample
   typedef struct {
      logic signed [rotBits-1:0] iExp;
      logic signed [rotBits-1:0] qExp;
      logic                      symExp;
      logic                      sym2xExp;
      int                        tag;
      string                     name;
   } expectEntry;

   logic                      clk;
   logic                      reset;
   logic                      symEn;
   logic                      sym2xEn;
   logic signed [rotBits-1:0] i;
   logic signed [rotBits-1:0] q;
   logic [ANGLE_BITS-1:0]     angle;
   logic                      symEnOut;
   logic                      sym2xEnOut;
   logic signed [rotBits-1:0] iOut;
   logic signed [rotBits-1:0] qOut;

   bit [31:0]  lcgState;
   string      testName;
   int         drivenCount;
   int         lastCheckedTag;
   int         checkCount;
   int         errorCount;
   int         timeoutCount;
   expectEntry pending[$];

   phaseRotator #(.rotBits(rotBits)) uut (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // -------------------------------------------------------------------------
   // Reference model and random numbers
   // -------------------------------------------------------------------------

   function automatic bit [31:0] nextRandom();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState;
   endfunction

   // Clamp a full integer result into the signed sample range
   function automatic logic signed [rotBits-1:0] clampToSample(input int v);
      if (v > (2 ** (rotBits - 1)) - 1) begin
         return maxSample;
      end else if (v < -(2 ** (rotBits - 1))) begin
         return minSample;
      end
      return v[rotBits-1:0];
   endfunction

   // Rotation by the table entry, floor division by 64 and saturation
   function automatic void rotateReference(
      input  logic signed [rotBits-1:0] iIn,
      input  logic signed [rotBits-1:0] qIn,
      input  logic [ANGLE_BITS-1:0]     angleIn,
      output logic signed [rotBits-1:0] iExp,
      output logic signed [rotBits-1:0] qExp
   );
      int c;
      int s;
      int iFull;
      int qFull;
      c = int'(COS_TABLE[angleIn]);
      s = int'(SIN_TABLE[angleIn]);
      iFull = int'(iIn) * c - int'(qIn) * s;
      qFull = int'(iIn) * s + int'(qIn) * c;
      // An arithmetic shift of a negative int rounds toward minus infinity
      iExp = clampToSample(iFull >>> COEFF_SHIFT);
      qExp = clampToSample(qFull >>> COEFF_SHIFT);
   endfunction

   // -------------------------------------------------------------------------
   // Scoreboard
   // -------------------------------------------------------------------------

   function automatic expectEntry makeEntry(input logic cleared);
      expectEntry e;
      e.tag = cleared ? 0 : drivenCount;
      e.name = testName;
      e.symExp = cleared ? 1'b0 : symEn;
      e.sym2xExp = cleared ? 1'b0 : sym2xEn;
      rotateReference(i, q, angle, e.iExp, e.qExp);
      if (cleared) begin
         e.iExp = '0;
         e.qExp = '0;
      end
      return e;
   endfunction

   task automatic compareEntry(input expectEntry e);
      checkCount++;
      assert (iOut === e.iExp) else begin
         $display("FAILED %s: iOut expected %0d, actual %0d", e.name, e.iExp, iOut);
         errorCount++;
      end
      assert (qOut === e.qExp) else begin
         $display("FAILED %s: qOut expected %0d, actual %0d", e.name, e.qExp, qOut);
         errorCount++;
      end
      assert (symEnOut === e.symExp) else begin
         $display("FAILED %s: symEnOut expected %0b, actual %0b", e.name, e.symExp, symEnOut);
         errorCount++;
      end
      assert (sym2xEnOut === e.sym2xExp) else begin
         $display("FAILED %s: sym2xEnOut expected %0b, actual %0b", e.name, e.sym2xExp,
                  sym2xEnOut);
         errorCount++;
      end
      if (e.tag > lastCheckedTag) begin
         lastCheckedTag = e.tag;
      end
   endtask

   // The queue mirrors the result, multiply and decode registers in that order.
   // Outputs read at a rising edge still hold the head entry
   initial begin : scoreboard
      expectEntry head;
      forever begin
         @(posedge clk);
         if (pending.size() == 3) begin
            head = pending.pop_front();
            compareEntry(head);
         end
         if (reset) begin
            // Reset clears every stage, so all three slots become zero
            pending.delete();
            repeat (3) pending.push_back(makeEntry(1'b1));
         end else if (pending.size() == 2) begin
            pending.push_back(makeEntry(1'b0));
         end
      end
   end

   // -------------------------------------------------------------------------
   // Stimulus
   // -------------------------------------------------------------------------

   task automatic driveSample(
      input logic signed [rotBits-1:0] iVal,
      input logic signed [rotBits-1:0] qVal,
      input logic [ANGLE_BITS-1:0]     angleVal,
      input logic                      symVal,
      input logic                      sym2xVal
   );
      @(negedge clk);
      i = iVal;
      q = qVal;
      angle = angleVal;
      symEn = symVal;
      sym2xEn = sym2xVal;
      drivenCount++;
   endtask

   // Random sample; dense strobes set about every second strobe bit
   task automatic driveRandom(input logic fixAngle, input logic [ANGLE_BITS-1:0] angleVal,
                              input logic dense);
      bit [31:0] r1;
      bit [31:0] r2;
      r1 = nextRandom();
      r2 = nextRandom();
      driveSample(r1[31 -: rotBits], r1[23 -: rotBits], fixAngle ? angleVal : r1[15:11],
                  dense ? r2[31] : r2[31] & r2[30], dense ? r2[29] : r2[29] & r2[28]);
   endtask

   task automatic waitForDrain();
      int waited;
      waited = 0;
      while (lastCheckedTag < drivenCount && waited < drainLimit) begin
         @(negedge clk);
         waited++;
      end
      if (lastCheckedTag < drivenCount) begin
         $display("Timeout: the last sample never reached the outputs within %0d cycles",
                  drainLimit);
         timeoutCount++;
      end
   endtask

   initial begin
      reset = 1'b1;
      symEn = 1'b0;
      sym2xEn = 1'b0;
      i = '0;
      q = '0;
      angle = '0;
      lcgState = 32'h94c5e569;
      testName = "reset state";
      // Two rising edges under reset, then release on the falling edge
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      repeat (4) driveSample('0, '0, '0, 1'b0, 1'b0);

      // Quarter turns swap and negate the components
      testName = "cardinal angles";
      for (int a = 0; a < 4; a++) begin
         repeat (16) driveRandom(1'b1, ANGLE_BITS'(8 * a), 1'b0);
      end

      testName = "all angles random";
      repeat (2000) driveRandom(1'b0, '0, 1'b0);

      // Corners at odd multiples of 45 degrees grow past full scale
      testName = "saturation";
      for (int a = 0; a < 4; a++) begin
         for (int k = 0; k < 4; k++) begin
            driveSample(k[0] ? minSample : maxSample, k[1] ? minSample : maxSample,
                        ANGLE_BITS'(4 + 8 * a), 1'b0, 1'b0);
         end
      end

      testName = "strobe alignment";
      repeat (4) driveRandom(1'b0, '0, 1'b0);
      repeat (4) driveSample(maxSample, minSample, 5'd3, 1'b1, 1'b1);
      repeat (200) driveRandom(1'b0, '0, 1'b1);

      testName = "reset mid-stream";
      repeat (50) driveRandom(1'b0, '0, 1'b1);
      @(negedge clk);
      reset = 1'b1;
      @(negedge clk);
      reset = 1'b0;
      repeat (50) driveRandom(1'b0, '0, 1'b1);

      waitForDrain();
      $display("Checks: %0d, value errors: %0d, timeouts: %0d", checkCount, errorCount,
               timeoutCount);
      if (errorCount == 0 && timeoutCount == 0 && checkCount > 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* sim/phaseRotator_asserts.sv */
/*
 * Concurrent checks on the phase rotator strobes, bound to the top level
 */
module phaseRotatorAsserts (
   input logic clk,
   input logic reset,
   input logic symEn,
   input logic sym2xEn,
   input logic symEnOut,
   input logic sym2xEnOut
);
   timeunit 1ns;
   timeprecision 1ps;

   // Goes high once the first reset has made the registers known
   logic settled = 1'b0;

   always_ff @(posedge clk) begin
      if (reset) begin
         settled <= 1'b1;
      end
   end

   // -------------------------------------------------------------------------
   // Strobe latency, only where no reset hit the three pipeline registers
   // -------------------------------------------------------------------------

   symEnDelay: assert property (@(posedge clk)
      settled && !$past(reset, 1) && !$past(reset, 2) && !$past(reset, 3)
      |-> symEnOut == $past(symEn, 3))
      else $error("symEnOut does not follow symEn by three cycles");

   sym2xEnDelay: assert property (@(posedge clk)
      settled && !$past(reset, 1) && !$past(reset, 2) && !$past(reset, 3)
      |-> sym2xEnOut == $past(sym2xEn, 3))
      else $error("sym2xEnOut does not follow sym2xEn by three cycles");

   // Reset clears the output register on the same edge
   strobesCleared: assert property (@(posedge clk)
      reset |=> !symEnOut && !sym2xEnOut)
      else $error("strobe outputs not cleared in the cycle after reset");

endmodule

bind phaseRotator phaseRotatorAsserts strobeChecks (.*);

/* src/phaseRotator.sv */
/*
 * Top level of the multi-h phase rotator: decode, execute and result
 * stages joined by the two stage buses, three cycles of latency
 */
module phaseRotator import rotatorPkg::*; #(
   // Sample width, passed down to every stage and both buses
   parameter int rotBits = 8
) (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      symEn,
   input  logic                      sym2xEn,
   input  logic signed [rotBits-1:0] i,
   input  logic signed [rotBits-1:0] q,
   input  logic [ANGLE_BITS-1:0]     angle,
   output logic                      symEnOut,
   output logic                      sym2xEnOut,
   output logic signed [rotBits-1:0] iOut,
   output logic signed [rotBits-1:0] qOut
);

   // -------------------------------------------------------------------------
   // Stage buses
   // -------------------------------------------------------------------------

   rotOperandIf #(.rotBits(rotBits)) operandBus ();
   rotProductIf #(.rotBits(rotBits)) productBus ();

   // -------------------------------------------------------------------------
   // Pipeline stages
   // -------------------------------------------------------------------------

   // Edge n+1 holds the sample and its coefficients
   coeffDecode #(.rotBits(rotBits)) decodeStage (
      .clk     (clk),
      .reset   (reset),
      .symEn   (symEn),
      .sym2xEn (sym2xEn),
      .i       (i),
      .q       (q),
      .angle   (angle),
      .operand (operandBus.source)
   );

   // Edge n+2 holds the four partial products
   complexMultiply #(.rotBits(rotBits)) multiplyStage (
      .clk     (clk),
      .reset   (reset),
      .operand (operandBus.sink),
      .product (productBus.source)
   );

   // Edge n+3 holds the rotated sample and its strobes
   rotateResult #(.rotBits(rotBits)) resultStage (
      .clk        (clk),
      .reset      (reset),
      .product    (productBus.sink),
      .symEnOut   (symEnOut),
      .sym2xEnOut (sym2xEnOut),
      .iOut       (iOut),
      .qOut       (qOut)
   );

endmodule

/* src/rotateResult.sv */
/*
 * Result stage of the phase rotator: sum and difference of the partial
 * products, scaling by the coefficient shift and saturation
 */
module rotateResult import rotatorPkg::*; #(
   parameter int rotBits = 8
) (
   input  logic                      clk,
   input  logic                      reset,
   rotProductIf.sink                 product,
   output logic                      symEnOut,
   output logic                      sym2xEnOut,
   output logic signed [rotBits-1:0] iOut,
   output logic signed [rotBits-1:0] qOut
);

   localparam int prodBits = rotBits + COEFF_BITS;
   // One guard bit keeps the sum of two products from wrapping
   localparam int sumBits  = prodBits + 1;

   // Signed output limits, sign extended to the sum width
   localparam logic signed [sumBits-1:0] satMax =
      {{(sumBits-rotBits+1){1'b0}}, {(rotBits-1){1'b1}}};
   localparam logic signed [sumBits-1:0] satMin =
      {{(sumBits-rotBits+1){1'b1}}, {(rotBits-1){1'b0}}};

   // Clamp a scaled sum into the rotBits range
   function automatic logic signed [rotBits-1:0] saturate(
      input logic signed [sumBits-1:0] value
   );
      if (value > satMax) begin
         return satMax[rotBits-1:0];
      end else if (value < satMin) begin
         return satMin[rotBits-1:0];
      end
      return value[rotBits-1:0];
   endfunction

   // -------------------------------------------------------------------------
   // Combine and scale
   // -------------------------------------------------------------------------

   logic signed [sumBits-1:0] iSum;
   logic signed [sumBits-1:0] qSum;
   logic signed [sumBits-1:0] iScaled;
   logic signed [sumBits-1:0] qScaled;

   always_comb begin
      // Real part is i*c - q*s, imaginary part is i*s + q*c
      iSum = sumBits'(product.iCr) - sumBits'(product.qCi);
      qSum = sumBits'(product.iCi) + sumBits'(product.qCr);
      // Arithmetic shift rounds toward minus infinity
      iScaled = iSum >>> COEFF_SHIFT;
      qScaled = qSum >>> COEFF_SHIFT;
   end

   // -------------------------------------------------------------------------
   // Output register
   // -------------------------------------------------------------------------

   // Corner samples can grow by up to sqrt(2) and hit the clamp
   always_ff @(posedge clk) begin
      if (reset) begin
         iOut       <= '0;
         qOut       <= '0;
         symEnOut   <= 1'b0;
         sym2xEnOut <= 1'b0;
      end else begin
         iOut       <= saturate(iScaled);
         qOut       <= saturate(qScaled);
         symEnOut   <= product.symEn;
         sym2xEnOut <= product.sym2xEn;
      end
   end

endmodule

/* src/complexMultiply.sv */
/*
 * Execute stage of the phase rotator: the four signed partial products
 * of the complex multiply, kept at full precision
 */
module complexMultiply import rotatorPkg::*; #(
   parameter int rotBits = 8
) (
   input  logic        clk,
   input  logic        reset,
   rotOperandIf.sink   operand,
   rotProductIf.source product
);

   // Exact product width of a rotBits sample times a coefficient
   localparam int prodBits = rotBits + COEFF_BITS;

   // -------------------------------------------------------------------------
   // Partial products
   // -------------------------------------------------------------------------

   // Both operands are sign extended to the product width first, so each
   // multiply is signed and no bit of the result is lost
   logic signed [prodBits-1:0] iCrNext;
   logic signed [prodBits-1:0] qCiNext;
   logic signed [prodBits-1:0] iCiNext;
   logic signed [prodBits-1:0] qCrNext;

   always_comb begin
      // Terms of the real part, i*c and q*s
      iCrNext = prodBits'(operand.i) * prodBits'(operand.cReal);
      qCiNext = prodBits'(operand.q) * prodBits'(operand.cImag);
      // Terms of the imaginary part, i*s and q*c
      iCiNext = prodBits'(operand.i) * prodBits'(operand.cImag);
      qCrNext = prodBits'(operand.q) * prodBits'(operand.cReal);
   end

   // -------------------------------------------------------------------------
   // Pipeline register
   // -------------------------------------------------------------------------

   // All rounding and clamping happen in the result stage, this one only
   // multiplies and delays the strobes by one register
   always_ff @(posedge clk) begin
      if (reset) begin
         product.iCr     <= '0;
         product.qCi     <= '0;
         product.iCi     <= '0;
         product.qCr     <= '0;
         product.symEn   <= 1'b0;
         product.sym2xEn <= 1'b0;
      end else begin
         product.iCr     <= iCrNext;
         product.qCi     <= qCiNext;
         product.iCi     <= iCiNext;
         product.qCr     <= qCrNext;
         product.symEn   <= operand.symEn;
         product.sym2xEn <= operand.sym2xEn;
      end
   end

   // A new sample enters on every clock, there is no stall path

endmodule

/* src/coeffDecode.sv */
/*
 * Decode stage of the phase rotator: angle to coefficient lookup, with
 * the sample and its strobes registered alongside
 */
module coeffDecode import rotatorPkg::*; #(
   parameter int rotBits = 8
) (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      symEn,
   input  logic                      sym2xEn,
   input  logic signed [rotBits-1:0] i,
   input  logic signed [rotBits-1:0] q,
   input  logic [ANGLE_BITS-1:0]     angle,
   rotOperandIf.source               operand
);

   // -------------------------------------------------------------------------
   // Coefficient lookup
   // -------------------------------------------------------------------------

   // The angle indexes both tables directly, every code is a valid step
   coeff_t cosEntry;
   coeff_t sinEntry;

   always_comb begin
      cosEntry = COS_TABLE[angle];
      sinEntry = SIN_TABLE[angle];
   end

   // -------------------------------------------------------------------------
   // Pipeline register
   // -------------------------------------------------------------------------

   // Sample, coefficients and strobes are all captured on the same edge,
   // so each coefficient pair stays tied to the sample it rotates
   always_ff @(posedge clk) begin
      if (reset) begin
         operand.i       <= '0;
         operand.q       <= '0;
         // Zero coefficients make the next stage's products known zero
         operand.cReal   <= '0;
         operand.cImag   <= '0;
         operand.symEn   <= 1'b0;
         operand.sym2xEn <= 1'b0;
      end else begin
         operand.i       <= i;
         operand.q       <= q;
         operand.cReal   <= cosEntry;
         operand.cImag   <= sinEntry;
         // Strobes only tag the sample, samples without one still rotate
         operand.symEn   <= symEn;
         operand.sym2xEn <= sym2xEn;
      end
   end

endmodule

/* src/rotatorIf.sv */
/*
 * Stage-to-stage buses of the phase rotator: operands from the decode
 * stage and partial products from the execute stage
 */

// ----------------------------------------------------------------------------
// Decode to execute
// ----------------------------------------------------------------------------

// One sample with its coefficient pair and the strobes that mark it
interface rotOperandIf import rotatorPkg::*; #(
   parameter int rotBits = 8
);
   logic signed [rotBits-1:0] i;
   logic signed [rotBits-1:0] q;
   coeff_t                    cReal;
   coeff_t                    cImag;
   logic                      symEn;
   logic                      sym2xEn;

   modport source (output i, q, cReal, cImag, symEn, sym2xEn);
   modport sink   (input  i, q, cReal, cImag, symEn, sym2xEn);
endinterface

// ----------------------------------------------------------------------------
// Execute to result
// ----------------------------------------------------------------------------

// Full precision partial products of one complex multiply
interface rotProductIf import rotatorPkg::*; #(
   parameter int rotBits = 8
);
   // Products keep every bit, sample width plus coefficient width
   logic signed [rotBits+COEFF_BITS-1:0] iCr;
   logic signed [rotBits+COEFF_BITS-1:0] qCi;
   logic signed [rotBits+COEFF_BITS-1:0] iCi;
   logic signed [rotBits+COEFF_BITS-1:0] qCr;
   logic                                 symEn;
   logic                                 sym2xEn;

   modport source (output iCr, qCi, iCi, qCr, symEn, sym2xEn);
   modport sink   (input  iCr, qCi, iCi, qCr, symEn, sym2xEn);
endinterface

/* src/rotatorPkg.sv */
/*
 * Shared constants and coefficient type for the multi-h phase rotator,
 * plus the 32-step cosine and sine lookup tables
 */
package rotatorPkg;

   // Each coefficient is a signed two's complement word
   localparam int COEFF_BITS = 8;

   // A coefficient of 64 means unity gain, so products drop 6 fraction bits
   localparam int COEFF_SHIFT = 6;

   // Five angle bits select one of 32 equal phase steps of 2*pi/32
   localparam int ANGLE_BITS = 5;
   localparam int ANGLE_STEPS = 2 ** ANGLE_BITS;

   typedef logic signed [COEFF_BITS-1:0] coeff_t;

   // --------------------------------------------------------------------------
   // Phase step tables
   // --------------------------------------------------------------------------

   // Entry k is round(64 * cos(2*pi*k/32)); one step is 11.25 degrees
   localparam coeff_t COS_TABLE [0:ANGLE_STEPS-1] = '{
       8'sd64,  8'sd63,  8'sd59,  8'sd53,  8'sd45,  8'sd36,  8'sd24,  8'sd12,
        8'sd0, -8'sd12, -8'sd24, -8'sd36, -8'sd45, -8'sd53, -8'sd59, -8'sd63,
      -8'sd64, -8'sd63, -8'sd59, -8'sd53, -8'sd45, -8'sd36, -8'sd24, -8'sd12,
        8'sd0,  8'sd12,  8'sd24,  8'sd36,  8'sd45,  8'sd53,  8'sd59,  8'sd63
   };

   // Entry k is round(64 * sin(2*pi*k/32)), a quarter turn behind the cosine
   localparam coeff_t SIN_TABLE [0:ANGLE_STEPS-1] = '{
        8'sd0,  8'sd12,  8'sd24,  8'sd36,  8'sd45,  8'sd53,  8'sd59,  8'sd63,
       8'sd64,  8'sd63,  8'sd59,  8'sd53,  8'sd45,  8'sd36,  8'sd24,  8'sd12,
        8'sd0, -8'sd12, -8'sd24, -8'sd36, -8'sd45, -8'sd53, -8'sd59, -8'sd63,
      -8'sd64, -8'sd63, -8'sd59, -8'sd53, -8'sd45, -8'sd36, -8'sd24, -8'sd12
   };

   // The tables never leave +/-64, so any coefficient fits COEFF_BITS with room

endpackage
